//--- vid_params.svh
`ifndef VID_PARAMS_SVH
`define VID_PARAMS_SVH

// register map, byte addresses of the host write bus
`define VID_REG_CTRL      8'h00
`define VID_REG_H1        8'h28     // h_size, h_end
`define VID_REG_H2        8'h30     // hsync start and end
`define VID_REG_V1        8'h38     // v_size, v_end
`define VID_REG_V2        8'h40     // vsync start and end
`define VID_REG_BASE      8'h48
`define VID_REG_LINE_INC  8'h50

// width of every horizontal and vertical timing value
`define VID_CNT_W         13

// pixel FIFO
`define VID_FIFO_DEPTH    32
`define VID_FIFO_AW       5

`define VID_REQ_PRIO      2'd3      // request priority for pixel reads

`endif

//--- vid_pkg.sv
`include "vid_params.svh"

package vid_pkg;

    typedef enum logic [2:0] {
        CMD_IDLE       = 3'd0,
        CMD_DATA       = 3'd1,
        CMD_READ       = 3'd2,
        CMD_DATA_FIRST = 3'd3,
        CMD_WRITE      = 3'd4
    } bus_cmd_e;

    typedef enum logic [1:0] {
        LEN_1  = 2'd0,
        LEN_4  = 2'd1,
        LEN_8  = 2'd2,
        LEN_16 = 2'd3
    } burst_len_e;

    typedef struct packed {
        logic [24:0] reserved;
        logic        enable;
        logic [5:0]  pclk;      // clocks per pixel, 0 acts as 1
    } ctrl_reg_t;

    typedef struct packed {
        logic [`VID_CNT_W-1:0] h_size;
        logic [`VID_CNT_W-1:0] h_end;     // last column of the line
    } h_timing_t;

    typedef struct packed {
        logic [`VID_CNT_W-1:0] hsync_start;
        logic [`VID_CNT_W-1:0] hsync_end;
    } h_sync_t;

    typedef struct packed {
        logic [`VID_CNT_W-1:0] v_size;
        logic [`VID_CNT_W-1:0] v_end;     // last line of the frame
    } v_timing_t;

    typedef struct packed {
        logic [`VID_CNT_W-1:0] vsync_start;
        logic [`VID_CNT_W-1:0] vsync_end;
    } v_sync_t;

    typedef struct packed {
        ctrl_reg_t   ctrl;
        h_timing_t   h1;
        h_sync_t     h2;
        v_timing_t   v1;
        v_sync_t     v2;
        logic [31:0] base;
        logic [31:0] line_inc;
    } vid_cfg_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    typedef struct packed {
        logic hsync;
        logic hblank;
        logic vsync;
        logic vblank;
    } sync_t;

    typedef enum logic {
        WR_ADDR,
        WR_DATA
    } write_state_e;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQ,
        FETCH_DATA
    } fetch_state_e;

endpackage

//--- vid_regs.sv
`timescale 1ns/10ps
`include "vid_params.svh"

module vid_regs (
    input  logic              clk,
    input  logic              reset,
    input  logic              sel,
    input  vid_pkg::bus_cmd_e cmd_in,
    input  logic [31:0]       addr_data_in,
    output vid_pkg::vid_cfg_t cfg
);
    import vid_pkg::*;

    write_state_e state;
    logic [7:0]   reg_addr;     // latched in the address cycle
    logic         addr_cycle;

    assign addr_cycle = (state == WR_ADDR) && sel && (cmd_in == CMD_WRITE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= WR_ADDR;
        end else begin
            case (state)
                WR_ADDR: begin
                    if (addr_cycle) begin
                        state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    state <= WR_ADDR;   // one data word per write
                end
                default: begin
                    state <= WR_ADDR;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (addr_cycle) begin
            reg_addr <= addr_data_in[7:0];
        end
    end

    // data cycle, the word lands in the addressed register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg <= '0;
        end else if (state == WR_DATA) begin
            case (reg_addr)
                `VID_REG_CTRL:     cfg.ctrl     <= ctrl_reg_t'(addr_data_in);
                `VID_REG_H1:       cfg.h1       <= h_timing_t'(addr_data_in[25:0]);
                `VID_REG_H2:       cfg.h2       <= h_sync_t'(addr_data_in[25:0]);
                `VID_REG_V1:       cfg.v1       <= v_timing_t'(addr_data_in[25:0]);
                `VID_REG_V2:       cfg.v2       <= v_sync_t'(addr_data_in[25:0]);
                `VID_REG_BASE:     cfg.base     <= addr_data_in;
                `VID_REG_LINE_INC: cfg.line_inc <= addr_data_in;
                default: begin
                    // unmapped address, word dropped
                end
            endcase
        end
    end

endmodule

//--- vid_fetch.sv
`timescale 1ns/10ps
`include "vid_params.svh"

module vid_fetch (
    input  logic                clk,
    input  logic                reset,
    input  vid_pkg::vid_cfg_t   cfg,
    input  vid_pkg::bus_cmd_e   cmd_in,
    input  logic [31:0]         addr_data_in,
    input  logic                fifo_half_full,
    output logic [1:0]          req,
    output vid_pkg::bus_cmd_e   cmd_out,
    output vid_pkg::burst_len_e len_out,
    output logic [31:0]         addr_data_out,
    output logic                push,
    output logic [31:0]         push_data
);
    import vid_pkg::*;

    fetch_state_e          state;
    logic [`VID_CNT_W-1:0] line;
    logic [`VID_CNT_W-1:0] col;
    logic [`VID_CNT_W-1:0] remain;      // words left in the current line
    logic [`VID_CNT_W-1:0] col_next;
    burst_len_e            next_len;
    burst_len_e            cur_len;     // burst in flight
    logic [4:0]            cur_words;
    logic [4:0]            beat_cnt;
    logic [31:0]           next_addr;
    logic                  beat;
    logic                  burst_done;

    function automatic logic [4:0] len_words(burst_len_e len);
        case (len)
            LEN_16:  return 5'd16;
            LEN_8:   return 5'd8;
            LEN_4:   return 5'd4;
            default: return 5'd1;
        endcase
    endfunction

    assign remain = cfg.h1.h_size - col;

    // largest burst that still fits in the line
    always_comb begin
        if (remain >= `VID_CNT_W'(16)) begin
            next_len = LEN_16;
        end else if (remain >= `VID_CNT_W'(8)) begin
            next_len = LEN_8;
        end else if (remain >= `VID_CNT_W'(4)) begin
            next_len = LEN_4;
        end else begin
            next_len = LEN_1;
        end
    end

    assign next_addr  = cfg.base + cfg.line_inc * 32'(line) + {17'd0, col, 2'b00};
    assign cur_words  = len_words(cur_len);
    assign col_next   = col + {8'd0, cur_words};

    assign beat       = (state == FETCH_DATA) &&
                        (cmd_in == CMD_DATA || cmd_in == CMD_DATA_FIRST);
    assign burst_done = (state == FETCH_DATA) && (beat_cnt == cur_words) &&
                        (cmd_in == CMD_IDLE);
    assign push       = beat;           // each returned word goes straight in
    assign push_data  = addr_data_in;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= FETCH_IDLE;
            line          <= '0;
            col           <= '0;
            cur_len       <= LEN_1;
            beat_cnt      <= '0;
            req           <= '0;
            cmd_out       <= CMD_IDLE;
            len_out       <= LEN_1;
            addr_data_out <= '0;
        end else begin
            req           <= '0;        // request lasts a single cycle
            cmd_out       <= CMD_IDLE;
            len_out       <= LEN_1;
            addr_data_out <= '0;
            case (state)
                FETCH_IDLE: begin
                    if (!cfg.ctrl.enable) begin
                        line <= '0;     // restart from the top of the frame
                        col  <= '0;
                    end else if (!fifo_half_full && cfg.h1.h_size != '0 &&
                                 cfg.v1.v_size != '0) begin
                        state <= FETCH_REQ;
                    end
                end
                FETCH_REQ: begin
                    req           <= `VID_REQ_PRIO;
                    cmd_out       <= CMD_READ;
                    len_out       <= next_len;
                    addr_data_out <= next_addr;
                    cur_len       <= next_len;
                    beat_cnt      <= '0;
                    state         <= FETCH_DATA;
                end
                FETCH_DATA: begin
                    if (beat) begin
                        beat_cnt <= beat_cnt + 5'd1;
                    end
                    if (burst_done) begin
                        state <= FETCH_IDLE;
                        if (col_next >= cfg.h1.h_size) begin
                            col <= '0;
                            if (line + 1'b1 >= cfg.v1.v_size) begin
                                line <= '0;
                            end else begin
                                line <= line + 1'b1;
                            end
                        end else begin
                            col <= col_next;
                        end
                    end
                end
                default: begin
                    state <= FETCH_IDLE;
                end
            endcase
        end
    end

endmodule

//--- vid_fifo.sv
`timescale 1ns/10ps
`include "vid_params.svh"

module vid_fifo #(
    parameter int DEPTH = `VID_FIFO_DEPTH,
    parameter int AW    = `VID_FIFO_AW      // DEPTH is 2**AW
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        push,
    input  logic [31:0] push_data,
    input  logic        pop,
    output logic [31:0] front_data,
    output logic        empty,
    output logic        half_full,
    output logic        full
);

    logic [31:0]   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;       // one extra bit to tell full from empty

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign front_data = mem[rd_ptr];    // oldest word, visible before the pop
    assign empty      = (count == '0);
    assign full       = (count == (AW+1)'(DEPTH));
    assign half_full  = (count >= (AW+1)'(DEPTH / 2));

endmodule

//--- vid_timing.sv
`timescale 1ns/10ps
`include "vid_params.svh"

module vid_timing (
    input  logic              clk,
    input  logic              reset,
    input  vid_pkg::vid_cfg_t cfg,
    input  logic              empty,
    input  logic [31:0]       front_data,
    output logic              pop,
    output vid_pkg::pixel_t   pixel,
    output vid_pkg::sync_t    sync
);
    import vid_pkg::*;

    logic                  run;
    logic [5:0]            div_cnt;     // clock within the current column
    logic [`VID_CNT_W-1:0] col;
    logic [`VID_CNT_W-1:0] line;
    logic                  first_tick;
    logic                  last_tick;
    logic                  active;
    logic                  stall;
    sync_t                 sync_next;

    assign first_tick = (div_cnt == '0);
    assign last_tick  = (cfg.ctrl.pclk <= 6'd1) || (div_cnt == cfg.ctrl.pclk - 6'd1);
    assign active     = (col < cfg.h1.h_size) && (line < cfg.v1.v_size);
    assign stall      = first_tick && active && empty;  // wait for the next word

    // with enable low the FIFO is drained so a restart begins on a clean frame
    assign pop = !empty && (!cfg.ctrl.enable || (run && first_tick && active));

    always_comb begin
        sync_next.hsync  = (col >= cfg.h2.hsync_start) && (col < cfg.h2.hsync_end);
        sync_next.hblank = (col >= cfg.h1.h_size);
        sync_next.vsync  = (line >= cfg.v2.vsync_start) && (line < cfg.v2.vsync_end);
        sync_next.vblank = (line >= cfg.v1.v_size);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            run     <= 1'b0;
            div_cnt <= '0;
            col     <= '0;
            line    <= '0;
            pixel   <= '0;
            sync    <= '0;
        end else if (!run) begin
            div_cnt <= '0;
            col     <= '0;
            line    <= '0;
            pixel   <= '0;
            sync    <= '0;
            if (cfg.ctrl.enable && !empty) begin
                run <= 1'b1;    // first word is in, start the frame
            end
        end else if (!cfg.ctrl.enable) begin
            run   <= 1'b0;
            pixel <= '0;
            sync  <= '0;
        end else if (!stall) begin
            sync <= sync_next;
            if (!active) begin
                pixel <= '0;    // blanking
            end else if (first_tick) begin
                pixel <= pixel_t'(front_data[23:0]);
            end
            if (last_tick) begin
                div_cnt <= '0;
                if (col == cfg.h1.h_end) begin
                    col <= '0;
                    if (line == cfg.v1.v_end) begin
                        line <= '0;
                    end else begin
                        line <= line + 1'b1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end else begin
                div_cnt <= div_cnt + 6'd1;
            end
        end
    end

endmodule

//--- vid_top.sv
`timescale 1ns/10ps

module vid_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                sel,
    input  vid_pkg::bus_cmd_e   cmd_in,
    input  logic [1:0]          len_in,     // bus field, register writes are single words
    input  logic [31:0]         addr_data_in,
    output logic [1:0]          req,
    output vid_pkg::bus_cmd_e   cmd_out,
    output vid_pkg::burst_len_e len_out,
    output logic [31:0]         addr_data_out,
    output vid_pkg::pixel_t     pixel,
    output vid_pkg::sync_t      sync
);
    import vid_pkg::*;

    vid_cfg_t    cfg;
    logic        fifo_push;
    logic [31:0] fifo_push_data;
    logic        fifo_pop;
    logic [31:0] fifo_front;
    logic        fifo_empty;
    logic        fifo_half_full;
    logic        fifo_full;       // for the bound checks

    vid_regs u_vid_regs (
        .clk          (clk),
        .reset        (reset),
        .sel          (sel),
        .cmd_in       (cmd_in),
        .addr_data_in (addr_data_in),
        .cfg          (cfg)
    );

    vid_fetch u_vid_fetch (
        .clk            (clk),
        .reset          (reset),
        .cfg            (cfg),
        .cmd_in         (cmd_in),
        .addr_data_in   (addr_data_in),
        .fifo_half_full (fifo_half_full),
        .req            (req),
        .cmd_out        (cmd_out),
        .len_out        (len_out),
        .addr_data_out  (addr_data_out),
        .push           (fifo_push),
        .push_data      (fifo_push_data)
    );

    vid_fifo u_vid_fifo (
        .clk        (clk),
        .reset      (reset),
        .push       (fifo_push),
        .push_data  (fifo_push_data),
        .pop        (fifo_pop),
        .front_data (fifo_front),
        .empty      (fifo_empty),
        .half_full  (fifo_half_full),
        .full       (fifo_full)
    );

    vid_timing u_vid_timing (
        .clk        (clk),
        .reset      (reset),
        .cfg        (cfg),
        .empty      (fifo_empty),
        .front_data (fifo_front),
        .pop        (fifo_pop),
        .pixel      (pixel),
        .sync       (sync)
    );

endmodule

//--- vid_properties.sv
`timescale 1ns/10ps

module vid_properties (
    input logic              clk,
    input logic              reset,
    input logic [1:0]        req,
    input logic              push,
    input logic              full,
    input logic              pop,
    input logic              empty,
    input vid_pkg::sync_t    sync
);

    // a read is a single cycle strobe
    req_one_cycle: assert property (@(posedge clk) disable iff (reset)
        (req != '0) |=> (req == '0))
        else $error("read request held longer than one cycle");

    no_push_full: assert property (@(posedge clk) disable iff (reset)
        !(push && full))
        else $error("push into a full FIFO");

    no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        !(pop && empty))
        else $error("pop from an empty FIFO");

    sync_in_reset: assert property (@(posedge clk) reset |-> (sync == '0))
        else $error("sync active during reset");

endmodule

bind vid_top vid_properties u_vid_properties (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .push    (fifo_push),
    .full    (fifo_full),
    .pop     (fifo_pop),
    .empty   (fifo_empty),
    .sync    (sync)
);

//--- tb_vid.sv
`timescale 1ns/10ps
`include "vid_params.svh"

module tb_vid;
    import vid_pkg::*;

    typedef struct packed {
        logic        sel;
        bus_cmd_e    cmd;
        logic [31:0] data;
    } bus_beat_t;

    logic        clk;
    logic        reset;
    logic        sel;
    bus_cmd_e    cmd_in;
    logic [1:0]  len_in;
    logic [31:0] addr_data_in;
    logic [1:0]  req;
    bus_cmd_e    cmd_out;
    burst_len_e  len_out;
    logic [31:0] addr_data_out;
    pixel_t      pixel;
    sync_t       sync;

    // frame as programmed by the host
    int          h_size, h_end, hs_start, hs_end;
    int          v_size, v_end, vs_start, vs_end;
    int          pclk_n;
    logic [31:0] base;
    logic [31:0] line_inc;
    logic [31:0] rng;
    bit          running;       // enable is set, monitors follow the DUT

    logic [7:0]  wr_addr;
    logic [31:0] wr_data;
    int          wr_req_cnt;
    int          wr_ack_cnt;

    bus_beat_t   mem_q[$];
    int          exp_line, exp_col;     // next expected read position
    int          req_seen;

    bit          started;
    int          m_line, m_col, m_div;
    int          hs_cycles, hb_cycles, vs_lines, vb_lines;
    bit          prev_hsync;
    int          frames_done;

    int          cycles;
    int          cycle_limit;

    vid_top u_vid_top (
        .clk           (clk),
        .reset         (reset),
        .sel           (sel),
        .cmd_in        (cmd_in),
        .len_in        (len_in),
        .addr_data_in  (addr_data_in),
        .req           (req),
        .cmd_out       (cmd_out),
        .len_out       (len_out),
        .addr_data_out (addr_data_out),
        .pixel         (pixel),
        .sync          (sync)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] mem_word(logic [31:0] a);
        return a ^ 32'h00A5_5A00;   // contents of the modelled memory
    endfunction

    function automatic logic [31:0] pixel_addr(int line, int col);
        return base + line_inc * 32'(line) + 32'(4 * col);
    endfunction

    function automatic int burst_words(burst_len_e len);
        case (len)
            LEN_16:  return 16;
            LEN_8:   return 8;
            LEN_4:   return 4;
            default: return 1;
        endcase
    endfunction

    function automatic int frame_cycles();
        return (h_end + 1) * (v_end + 1) * pclk_n;
    endfunction

    task automatic check_pixel(pixel_t got, pixel_t exp, string msg);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
            $display("tests failed");
            $fatal(1, "pixel mismatch");
        end
    endtask

    task automatic check_sync(sync_t got, sync_t exp, string msg);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %b expected %b", $time, msg, got, exp);
            $display("tests failed");
            $fatal(1, "sync mismatch");
        end
    endtask

    task automatic check_word(logic [31:0] got, logic [31:0] exp, string msg);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
            $display("tests failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_len(burst_len_e got, burst_len_e exp, string msg);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %0d expected %0d", $time, msg, got, exp);
            $display("tests failed");
            $fatal(1, "burst length mismatch");
        end
    endtask

    task automatic check_count(int got, int exp, string msg);
        if (got != exp) begin
            $display("FAILED at %0t ns: %s, got %0d expected %0d", $time, msg, got, exp);
            $display("tests failed");
            $fatal(1, "count mismatch");
        end
    endtask

    // memory model and host writes share the one bus
    initial begin : bus_driver
        bus_beat_t  beat;
        burst_len_e exp_len;
        int         remain;
        int         words;
        bit         wr_data_next;
        sel          = 1'b0;
        cmd_in       = CMD_IDLE;
        addr_data_in = '0;
        wr_data_next = 1'b0;
        forever begin
            @(negedge clk);
            if (cmd_out == CMD_READ) begin
                if (running) begin
                    remain = h_size - exp_col;
                    words  = (remain >= 16) ? 16 : (remain >= 8) ? 8 : (remain >= 4) ? 4 : 1;
                    case (words)
                        16:      exp_len = LEN_16;
                        8:       exp_len = LEN_8;
                        4:       exp_len = LEN_4;
                        default: exp_len = LEN_1;
                    endcase
                    check_word(32'(req), 32'(`VID_REQ_PRIO), "read request priority");
                    check_word(addr_data_out, pixel_addr(exp_line, exp_col), "read address");
                    check_len(len_out, exp_len, "burst length");
                    exp_col = exp_col + words;
                    if (exp_col >= h_size) begin
                        exp_col  = 0;
                        exp_line = (exp_line + 1 >= v_size) ? 0 : exp_line + 1;
                    end
                    req_seen++;
                end
                for (int i = 0; i < burst_words(len_out); i++) begin
                    beat.sel  = 1'b0;
                    beat.cmd  = (i == 0) ? CMD_DATA_FIRST : CMD_DATA;
                    beat.data = mem_word(addr_data_out + 32'(4 * i));
                    mem_q.push_back(beat);
                end
            end else if (!running) begin
                exp_line = 0;
                exp_col  = 0;
            end
            if (wr_data_next) begin
                sel          = 1'b1;    // data cycle right after the address
                cmd_in       = CMD_IDLE;
                addr_data_in = wr_data;
                wr_data_next = 1'b0;
                wr_ack_cnt++;
            end else if (mem_q.size() > 0) begin
                beat         = mem_q.pop_front();
                sel          = beat.sel;
                cmd_in       = beat.cmd;
                addr_data_in = beat.data;
            end else if (wr_req_cnt != wr_ack_cnt) begin
                sel          = 1'b1;
                cmd_in       = CMD_WRITE;
                addr_data_in = {24'd0, wr_addr};
                wr_data_next = 1'b1;
            end else begin
                sel          = 1'b0;
                cmd_in       = CMD_IDLE;
                addr_data_in = '0;
            end
        end
    end

    // follows col, line and pixel clock from the first pixel on
    always @(negedge clk) begin : frame_monitor
        pixel_t      exp_pix;
        sync_t       exp_sync;
        logic [31:0] word;
        if (!running) begin
            started = 1'b0;
        end else begin
            if (!started && pixel != '0) begin
                started    = 1'b1;
                m_line     = 0;
                m_col      = 0;
                m_div      = 0;
                hs_cycles  = 0;
                hb_cycles  = 0;
                vs_lines   = 0;
                vb_lines   = 0;
                prev_hsync = 1'b0;
            end
            if (started) begin
                exp_sync.hsync  = (m_col >= hs_start) && (m_col < hs_end);
                exp_sync.hblank = (m_col >= h_size);
                exp_sync.vsync  = (m_line >= vs_start) && (m_line < vs_end);
                exp_sync.vblank = (m_line >= v_size);
                word    = mem_word(pixel_addr(m_line, m_col));
                exp_pix = (exp_sync.hblank || exp_sync.vblank) ? '0 : pixel_t'(word[23:0]);
                check_sync(sync, exp_sync, "sync outputs");
                check_pixel(pixel, exp_pix, "pixel value");
                if (sync.hsync) hs_cycles++;
                if (sync.hblank) hb_cycles++;
                if (sync.hsync && !prev_hsync) begin   // one rising edge per line
                    if (sync.vsync) vs_lines++;
                    if (sync.vblank) vb_lines++;
                end
                prev_hsync = sync.hsync;
                if (m_div == pclk_n - 1) begin
                    m_div = 0;
                    if (m_col == h_end) begin
                        check_count(hs_cycles, (hs_end - hs_start) * pclk_n, "hsync cycles");
                        check_count(hb_cycles, (h_end + 1 - h_size) * pclk_n, "hblank cycles");
                        hs_cycles = 0;
                        hb_cycles = 0;
                        m_col     = 0;
                        if (m_line == v_end) begin
                            check_count(vs_lines, vs_end - vs_start, "vsync lines");
                            check_count(vb_lines, v_end + 1 - v_size, "vblank lines");
                            vs_lines = 0;
                            vb_lines = 0;
                            m_line   = 0;
                            frames_done++;
                        end else begin
                            m_line++;
                        end
                    end else begin
                        m_col++;
                    end
                end else begin
                    m_div++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the frames never completed", cycles);
            $display("tests failed");
            $fatal(1, "timeout");
        end
    end

    task automatic write_reg(logic [7:0] addr, logic [31:0] data);
        wr_addr = addr;
        wr_data = data;
        wr_req_cnt++;
        wait (wr_ack_cnt == wr_req_cnt);
    endtask

    task automatic write_ctrl(bit en);
        ctrl_reg_t ctrl;
        ctrl.reserved = '0;
        ctrl.enable   = en;
        ctrl.pclk     = 6'(pclk_n);
        write_reg(`VID_REG_CTRL, ctrl);
    endtask

    task automatic set_frame(int hsz, int hend, int hss, int hse,
                             int vsz, int vend, int vss, int vse, int pc);
        h_size   = hsz;
        h_end    = hend;
        hs_start = hss;
        hs_end   = hse;
        v_size   = vsz;
        v_end    = vend;
        vs_start = vss;
        vs_end   = vse;
        pclk_n   = pc;
    endtask

    // random frame placement, first pixel kept nonzero so the start is visible
    task automatic program_frame();
        h_timing_t h1;
        h_sync_t   h2;
        v_timing_t v1;
        v_sync_t   v2;
        rng      = xorshift(rng);
        base     = rng & 32'hFFFF_FFFC;
        if (((base ^ 32'h00A5_5A00) & 32'h00FF_FFFF) == 32'h0) base = base + 32'd4;
        rng      = xorshift(rng);
        line_inc = 32'h0000_0100 + (rng & 32'h0000_3FF0);
        h1.h_size      = 13'(h_size);
        h1.h_end       = 13'(h_end);
        h2.hsync_start = 13'(hs_start);
        h2.hsync_end   = 13'(hs_end);
        v1.v_size      = 13'(v_size);
        v1.v_end       = 13'(v_end);
        v2.vsync_start = 13'(vs_start);
        v2.vsync_end   = 13'(vs_end);
        write_reg(`VID_REG_H1, 32'(h1));
        write_reg(`VID_REG_H2, 32'(h2));
        write_reg(`VID_REG_V1, 32'(v1));
        write_reg(`VID_REG_V2, 32'(v2));
        write_reg(`VID_REG_BASE, base);
        write_reg(`VID_REG_LINE_INC, line_inc);
        @(posedge clk);
        running = 1'b1;
        write_ctrl(1'b1);
    endtask

    task automatic reset_values_zero();
        @(negedge clk);
        check_word(32'(req), 32'h0, "req after reset");
        check_word(32'(cmd_out), 32'h0, "cmd_out after reset");
        check_len(len_out, LEN_1, "len_out after reset");
        check_word(addr_data_out, 32'h0, "addr_data_out after reset");
        check_pixel(pixel, '0, "pixel after reset");
        check_sync(sync, '0, "sync after reset");
    endtask

    // h_size 22 gives bursts of 16, 4, 1 and 1
    task automatic read_request_order();
        set_frame(22, 29, 24, 27, 6, 8, 7, 8, 4);
        program_frame();
        wait (req_seen >= 4 * v_size);
    endtask

    task automatic frame_output(int frames);
        int target;
        target = frames_done + frames;
        wait (frames_done >= target);
    endtask

    task automatic smaller_frame();
        @(posedge clk);
        running = 1'b0;
        write_ctrl(1'b0);
        repeat (64) @(posedge clk);    // bursts in flight finish, FIFO drains
        set_frame(9, 13, 10, 12, 4, 6, 5, 6, 5);
        program_frame();
        frame_output(2);
    endtask

    initial begin
        reset  = 1'b1;
        len_in = 2'b00;
        rng    = 32'h4753_298a;
        set_frame(9, 13, 10, 12, 4, 6, 5, 6, 5);
        cycle_limit = 3 * frame_cycles();
        set_frame(22, 29, 24, 27, 6, 8, 7, 8, 4);
        cycle_limit = 2 * (cycle_limit + 3 * frame_cycles());
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        reset_values_zero();
        read_request_order();
        frame_output(2);
        smaller_frame();
        $display("all tests passed");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
vid_pkg.sv
vid_regs.sv
vid_fetch.sv
vid_fifo.sv
vid_timing.sv
vid_top.sv
vid_properties.sv
tb_vid.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f filelist.f --top-module tb_vid -o tb_vid
	@out=$$(./obj_dir/tb_vid 2>&1); echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
